/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_mem_subsystem
FILELIST = all.f
OBJ_DIR  = obj_dir

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuild only when a source or the file list changes.
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The pattern file is read relative to the project root.
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
src/mem_map_pkg.sv
src/phys_bus_if.sv
src/bank_mapper.sv
src/phys_decode.sv
src/onchip_ram.sv
src/monitor_rom.sv
src/extram_port.sv
src/mem_subsystem_top.sv
dv/sram_model.sv
dv/tb_mem_subsystem.sv

/* dv/mem_patterns.txt */
# Columns: test number, W or R, CPU address (hex), byte (hex)
# W gives data to write, R gives expected read data; in test 5 the LCG supplies the bytes
1 R FFE0 F0
1 R FFE7 F7
1 R FFEF FF
1 R F000 D8
1 R F001 78
1 R FFFC 00
1 R FFFD F0
2 W D000 5A
2 W DFFF C3
2 R D000 5A
2 R DFFF C3
2 W F005 00
2 R F005 A9
3 W FFE2 05
3 W FFE3 05
3 W 2123 3C
3 W 2FFE 81
3 R 3123 3C
3 R 3FFE 81
3 R FFE2 05
4 W FFE4 80
4 R FFE4 80
4 W 4010 77
4 R 4010 FF
5 W 2200 00
5 W D200 00
5 R 2200 00
5 R FFE3 05
5 R D200 00
5 W 2201 00
5 R 2201 00
5 R FFE4 80

/* dv/sram_model.sv */
module sram_model #(
    parameter int addr_w = 17
)
(
    input  logic [addr_w-1:0] addr,
    inout  wire  [7:0]        data,
    input  logic              cs_n,
    input  logic              we_n,
    input  logic              oe_n
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = 1 << addr_w;

    // Settle time before a write is taken, well inside one bus cycle.
    localparam int WRITE_SETTLE = 5;

    logic [7:0] mem [DEPTH];

    // Output drivers on only for a plain read.
    assign data = (!cs_n && !oe_n && we_n) ? mem[addr] : 'z;

    // Address, data and strobes all move at the clock edge.
    // The write is taken once the pins have settled.
    always @(addr or data or cs_n or we_n)
    begin
        #WRITE_SETTLE;
        if (!cs_n && !we_n)
            mem[addr] = data;
    end

endmodule

/* dv/tb_mem_subsystem.sv */
module tb_mem_subsystem;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 100;
    localparam int EXT_ADDR_W = 17;
    localparam int RAND_TEST  = 5;

    logic                  hwclk;
    logic                  rst_n;
    logic                  strb;
    logic                  rw;
    logic [15:0]           addr;
    logic [7:0]            wdata;
    logic                  ack;
    logic [7:0]            rdata;
    logic [EXT_ADDR_W-1:0] extaddr;
    wire  [7:0]            extdata;
    logic                  extram_cs_n;
    logic                  extram_we_n;
    logic                  extram_oe_n;

    // Pattern table as read from the data file.
    int          pat_test [$];
    bit          pat_write [$];
    logic [15:0] pat_addr [$];
    logic [7:0]  pat_data [$];
    int          n_lines = 0;
    bit          loaded = 1'b0;

    // Accesses in flight, oldest first.
    logic [15:0] fly_addr [$];
    bit          fly_read [$];
    logic [7:0]  fly_exp [$];
    int          fly_edge [$];

    // Random bytes written in the stress test, by CPU address.
    logic [7:0]  rand_wr [logic [15:0]];
    logic [31:0] lcg_state = 32'hda2c_022d;

    int cyc = 0;
    int errors = 0;
    int checks = 0;
    int pass_tests = 0;
    int fail_tests = 0;

    mem_subsystem_top #(.ext_addr_w(EXT_ADDR_W), .ram_addr_w(12)) u_dut (
        .hwclk       (hwclk),
        .rst_n       (rst_n),
        .strb        (strb),
        .rw          (rw),
        .addr        (addr),
        .wdata       (wdata),
        .ack         (ack),
        .rdata       (rdata),
        .extaddr     (extaddr),
        .extdata     (extdata),
        .extram_cs_n (extram_cs_n),
        .extram_we_n (extram_we_n),
        .extram_oe_n (extram_oe_n)
    );

    sram_model #(.addr_w(EXT_ADDR_W)) u_sram (
        .addr (extaddr),
        .data (extdata),
        .cs_n (extram_cs_n),
        .we_n (extram_we_n),
        .oe_n (extram_oe_n)
    );

    initial
    begin
        hwclk = 1'b0;
        forever #(CLK_PERIOD / 2) hwclk = ~hwclk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bit load_patterns();
        int          fd;
        int          t;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [15:0] a;
        logic [7:0]  d;
        fd = $fopen("dv/mem_patterns.txt", "r");
        if (fd == 0)
            return 1'b0;
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() > 1 && line[0] != "#")
            begin
                n = $sscanf(line, "%d %c %h %h", t, op, a, d);
                if (n == 4)
                begin
                    pat_test.push_back(t);
                    pat_write.push_back(op == "W");
                    pat_addr.push_back(a);
                    pat_data.push_back(d);
                end
            end
        end
        $fclose(fd);
        n_lines = pat_test.size();
        loaded  = 1'b1;
        return 1'b1;
    endfunction

    function automatic void retire_oldest();
        void'(fly_addr.pop_front());
        void'(fly_read.pop_front());
        void'(fly_exp.pop_front());
        void'(fly_edge.pop_front());
    endfunction

    task automatic issue(input int i);
        logic [7:0] d;
        d = pat_data[i];
        @(posedge hwclk);
        // The stress test replaces file data with LCG bytes and reads them back.
        if (pat_test[i] == RAND_TEST && pat_write[i])
        begin
            lcg_state = lcg_next(lcg_state);
            d = lcg_state[23:16];
            rand_wr[pat_addr[i]] = d;
        end
        else if (pat_test[i] == RAND_TEST && rand_wr.exists(pat_addr[i]))
        begin
            d = rand_wr[pat_addr[i]];
        end
        strb  <= 1'b1;
        rw    <= !pat_write[i];
        addr  <= pat_addr[i];
        wdata <= pat_write[i] ? d : 8'h00;
        fly_addr.push_back(pat_addr[i]);
        fly_read.push_back(!pat_write[i]);
        fly_exp.push_back(d);
        // Sampled at the next edge, so the negedge after it is two counts on.
        fly_edge.push_back(cyc + 2);
    endtask

    task automatic idle();
        @(posedge hwclk);
        strb <= 1'b0;
    endtask

    task automatic drain();
        idle();
        while (fly_addr.size() != 0)
            idle();
    endtask

    task automatic close_test(input int t, input int err_start);
        drain();
        if (errors == err_start)
        begin
            pass_tests++;
            $display("Test %0d passed", t);
        end
        else
        begin
            fail_tests++;
            $display("Test %0d failed with %0d errors", t, errors - err_start);
        end
    endtask

    task automatic run_patterns();
        int cur_test;
        int err_start;
        repeat (10) @(posedge hwclk);
        rst_n <= 1'b1;
        idle();
        cur_test  = pat_test[0];
        err_start = errors;
        for (int i = 0; i < n_lines; i++)
        begin
            if (pat_test[i] != cur_test)
            begin
                close_test(cur_test, err_start);
                cur_test  = pat_test[i];
                err_start = errors;
            end
            issue(i);
            // Only the stress test keeps the strobe up on every cycle.
            if (cur_test != RAND_TEST)
                drain();
        end
        close_test(cur_test, err_start);
    endtask

    // Responses are checked mid-cycle, where ack and rdata are stable.
    always @(negedge hwclk)
    begin
        cyc = cyc + 1;
        if (ack === 1'b1)
        begin
            assert (fly_addr.size() != 0)
            else
            begin
                $display("Unexpected ack at %0t with no access outstanding", $time);
                errors++;
            end
            if (fly_addr.size() != 0)
            begin
                checks++;
                assert (cyc - fly_edge[0] == 2)
                else
                begin
                    $display("Fail at %0t: ack for %h came %0d cycles after its strobe",
                             $time, fly_addr[0], cyc - fly_edge[0]);
                    errors++;
                end
                if (fly_read[0])
                begin
                    assert (rdata === fly_exp[0])
                    else
                    begin
                        $display("Fail at %0t: read of %h returned %h, expected %h",
                                 $time, fly_addr[0], rdata, fly_exp[0]);
                        errors++;
                    end
                end
                retire_oldest();
            end
        end
        else if (fly_addr.size() != 0)
        begin
            assert (cyc - fly_edge[0] < 2)
            else
            begin
                $display("No ack arrived for the access to %h at %0t", fly_addr[0], $time);
                errors++;
                retire_oldest();
            end
        end
    end

    initial
    begin
        wait (loaded);
        #((n_lines + 20) * CLK_PERIOD * 4);
        $display("Watchdog expired before all patterns completed");
        $display("Test failures found");
        $finish;
    end

    initial
    begin
        strb  = 1'b0;
        rw    = 1'b1;
        addr  = '0;
        wdata = '0;
        rst_n = 1'b0;
        if (!load_patterns())
        begin
            $display("Pattern file dv/mem_patterns.txt could not be opened");
            $display("Test failures found");
            $finish;
        end
        else
        begin
            run_patterns();
            $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
                     pass_tests, fail_tests, checks, errors);
            if (errors == 0 && fail_tests == 0)
                $display("All tests passed!");
            else
                $display("Test failures found");
            $finish;
        end
    end

endmodule

/* src/bank_mapper.sv */
module bank_mapper
    import mem_map_pkg::*;
(
    input  logic       hwclk,
    input  logic       rst_n,
    input  logic       strb,
    input  logic       rw,
    input  cpu_addr_t  addr,
    input  byte_t      wdata,
    phys_bus_if.launch bus
);

    // Bank i comes out of reset as $F0 + i, an identity map into the top.
    localparam bank_t BANK_RESET_BASE = 8'hF0;

    bank_t bank_reg [16];
    logic  win_hit;
    bank_t page_bank;

    assign win_hit   = (addr[15:4] == MMU_WINDOW);
    assign page_bank = bank_reg[addr[15:12]];

    // Window writes take effect at the strobe edge.
    always_ff @(posedge hwclk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 16; i++)
                bank_reg[i] <= BANK_RESET_BASE + bank_t'(i);
        end
        else if (strb && win_hit && !rw)
        begin
            bank_reg[addr[3:0]] <= wdata;
        end
    end

    always_ff @(posedge hwclk)
    begin
        if (!rst_n)
        begin
            bus.valid   <= 1'b0;
            bus.mmu_hit <= 1'b0;
        end
        else
        begin
            bus.valid   <= strb;
            bus.mmu_hit <= strb && win_hit;
        end
    end

    // Payload of the stage.
    always_ff @(posedge hwclk)
    begin
        if (strb)
        begin
            bus.paddr <= {page_bank, addr[11:0]};
            bus.wdata <= wdata;
            bus.we    <= !rw;
            if (win_hit && rw)
                bus.mmu_rdata <= bank_reg[addr[3:0]];
        end
    end

    // The host must present a known address and direction with every strobe.
    a_strobe_known: assert property (
        @(posedge hwclk) disable iff (!rst_n) strb |-> !$isunknown({rw, addr}))
        else $error("strobe with an unknown address or direction");

endmodule

/* src/extram_port.sv */
module extram_port
    import mem_map_pkg::*;
#(
    parameter int ext_addr_w = 17
)
(
    input  logic                  hwclk,
    input  logic                  rst_n,
    input  logic                  sel,
    phys_bus_if.target            bus,
    output byte_t                 rdata,
    output logic [ext_addr_w-1:0] extaddr,
    inout  wire byte_t            extdata,
    output logic                  extram_cs_n,
    output logic                  extram_we_n,
    output logic                  extram_oe_n
);

    logic wr_cycle;
    logic rd_cycle;

    assign wr_cycle = sel && bus.we;
    assign rd_cycle = sel && !bus.we;

    // Pins follow the stage for the whole cycle; all controls are active low.
    assign extaddr     = bus.paddr[ext_addr_w-1:0];
    assign extram_cs_n = !sel;
    assign extram_we_n = !wr_cycle;
    assign extram_oe_n = !rd_cycle;

    // Drive the data bus only while writing.
    assign extdata = wr_cycle ? bus.wdata : 'z;

    // Sample the SRAM output at the end of the read cycle.
    always_ff @(posedge hwclk)
    begin
        if (rd_cycle)
            rdata <= extdata;
    end

    // The SRAM is only enabled while the stage holds a live access.
    a_cs_needs_valid: assert property (
        @(posedge hwclk) disable iff (!rst_n) !extram_cs_n |-> bus.valid)
        else $error("SRAM enabled with an empty stage");

endmodule

/* src/mem_map_pkg.sv */
package mem_map_pkg;

    // Host address as seen by the CPU.
    typedef logic [15:0] cpu_addr_t;

    // Mapped physical address, bank byte on top of a 12-bit page offset.
    typedef logic [19:0] phys_addr_t;

    // One bank register, supplies physical bits 19:12.
    typedef logic [7:0] bank_t;

    typedef logic [7:0] byte_t;

    // Bank registers live at $FFE0-$FFEF in CPU space.
    localparam logic [11:0] MMU_WINDOW = 12'hFFE;

    // Physical pages of the on-chip targets.
    localparam bank_t RAM_PAGE = 8'hFD;
    localparam bank_t ROM_PAGE = 8'hFF;

    // Value returned for reads that hit nothing.
    localparam byte_t OPEN_BUS = 8'hFF;

endpackage

/* src/mem_subsystem_top.sv */
module mem_subsystem_top
    import mem_map_pkg::*;
#(
    parameter int ext_addr_w = 17,
    parameter int ram_addr_w = 12
)
(
    input  logic                  hwclk,
    input  logic                  rst_n,
    input  logic                  strb,
    input  logic                  rw,
    input  cpu_addr_t             addr,
    input  byte_t                 wdata,
    output logic                  ack,
    output byte_t                 rdata,
    output logic [ext_addr_w-1:0] extaddr,
    inout  wire byte_t            extdata,
    output logic                  extram_cs_n,
    output logic                  extram_we_n,
    output logic                  extram_oe_n
);

    logic  ext_sel;
    logic  ram_sel;
    logic  rom_sel;
    byte_t ext_rdata;
    byte_t ram_rdata;
    byte_t rom_rdata;

    phys_bus_if u_bus ();

    bank_mapper u_mapper (
        .hwclk (hwclk),
        .rst_n (rst_n),
        .strb  (strb),
        .rw    (rw),
        .addr  (addr),
        .wdata (wdata),
        .bus   (u_bus)
    );

    phys_decode #(.ext_addr_w(ext_addr_w)) u_decode (
        .hwclk     (hwclk),
        .rst_n     (rst_n),
        .bus       (u_bus),
        .ext_sel   (ext_sel),
        .ram_sel   (ram_sel),
        .rom_sel   (rom_sel),
        .ext_rdata (ext_rdata),
        .ram_rdata (ram_rdata),
        .rom_rdata (rom_rdata),
        .ack       (ack),
        .rdata     (rdata)
    );

    onchip_ram #(.ram_addr_w(ram_addr_w)) u_ram (
        .hwclk (hwclk),
        .sel   (ram_sel),
        .bus   (u_bus),
        .rdata (ram_rdata)
    );

    monitor_rom u_rom (
        .hwclk (hwclk),
        .sel   (rom_sel),
        .bus   (u_bus),
        .rdata (rom_rdata)
    );

    extram_port #(.ext_addr_w(ext_addr_w)) u_extram (
        .hwclk       (hwclk),
        .rst_n       (rst_n),
        .sel         (ext_sel),
        .bus         (u_bus),
        .rdata       (ext_rdata),
        .extaddr     (extaddr),
        .extdata     (extdata),
        .extram_cs_n (extram_cs_n),
        .extram_we_n (extram_we_n),
        .extram_oe_n (extram_oe_n)
    );

endmodule

/* src/monitor_rom.sv */
module monitor_rom
    import mem_map_pkg::*;
(
    input  logic       hwclk,
    input  logic       sel,
    phys_bus_if.target bus,
    output byte_t      rdata
);

    logic [11:0] offset;
    byte_t       rom_byte;

    assign offset = bus.paddr[11:0];

    // Entry stub at $F000, vectors at $FFFA, NOP fill everywhere else.
    always_comb
    begin
        case (offset)
            12'h000: rom_byte = 8'hD8;  // CLD
            12'h001: rom_byte = 8'h78;  // SEI
            12'h002: rom_byte = 8'hA2;  // LDX #$FF
            12'h003: rom_byte = 8'hFF;
            12'h004: rom_byte = 8'h9A;  // TXS
            12'h005: rom_byte = 8'hA9;  // LDA #$F0
            12'h006: rom_byte = 8'hF0;
            12'h007: rom_byte = 8'h8D;  // STA $FFE2
            12'h008: rom_byte = 8'hE2;
            12'h009: rom_byte = 8'hFF;
            12'h00A: rom_byte = 8'h58;  // CLI
            12'h00B: rom_byte = 8'h4C;  // JMP $F00B
            12'h00C: rom_byte = 8'h0B;
            12'h00D: rom_byte = 8'hF0;
            12'h00E: rom_byte = 8'h40;  // RTI, shared by NMI and IRQ
            12'hFFA: rom_byte = 8'h0E;
            12'hFFB: rom_byte = 8'hF0;
            12'hFFC: rom_byte = 8'h00;
            12'hFFD: rom_byte = 8'hF0;
            12'hFFE: rom_byte = 8'h0E;
            12'hFFF: rom_byte = 8'hF0;
            default: rom_byte = 8'hEA;
        endcase
    end

    always_ff @(posedge hwclk)
    begin
        if (sel && !bus.we)
            rdata <= rom_byte;
    end

endmodule

/* src/onchip_ram.sv */
module onchip_ram
    import mem_map_pkg::*;
#(
    parameter int ram_addr_w = 12
)
(
    input  logic       hwclk,
    input  logic       sel,
    phys_bus_if.target bus,
    output byte_t      rdata
);

    localparam int ram_depth = 1 << ram_addr_w;

    byte_t                 mem [ram_depth];
    logic [ram_addr_w-1:0] word_addr;

    assign word_addr = bus.paddr[ram_addr_w-1:0];

    // Single port, read data registered one edge after the stage.
    always_ff @(posedge hwclk)
    begin
        if (sel)
        begin
            if (bus.we)
                mem[word_addr] <= bus.wdata;
            else
                rdata <= mem[word_addr];
        end
    end

endmodule

/* src/phys_bus_if.sv */
interface phys_bus_if
    import mem_map_pkg::*;
();

    // One registered physical access, launched by the mapper.
    logic       valid;
    phys_addr_t paddr;
    byte_t      wdata;
    logic       we;

    // Window accesses are answered by the mapper itself.
    logic       mmu_hit;
    byte_t      mmu_rdata;

    modport launch (output valid, paddr, wdata, we, mmu_hit, mmu_rdata);

    modport decode (input valid, paddr, wdata, we, mmu_hit, mmu_rdata);

    modport target (input valid, paddr, wdata, we);

endinterface

/* src/phys_decode.sv */
module phys_decode
    import mem_map_pkg::*;
#(
    parameter int ext_addr_w = 17
)
(
    input  logic       hwclk,
    input  logic       rst_n,
    phys_bus_if.decode bus,
    output logic       ext_sel,
    output logic       ram_sel,
    output logic       rom_sel,
    input  byte_t      ext_rdata,
    input  byte_t      ram_rdata,
    input  byte_t      rom_rdata,
    output logic       ack,
    output byte_t      rdata
);

    logic  target_cycle;
    logic  ext_hit;
    bank_t page;
    logic  pend;
    logic  ext_q;
    logic  ram_q;
    logic  rom_q;
    logic  mmu_q;
    byte_t mmu_rdata_q;
    byte_t rdata_mux;

    assign page         = bus.paddr[19:12];
    assign target_cycle = bus.valid && !bus.mmu_hit;
    // External SRAM owns everything with no bits set above its address width.
    assign ext_hit      = ((bus.paddr >> ext_addr_w) == '0);

    assign ext_sel = target_cycle && ext_hit;
    assign ram_sel = target_cycle && (page == RAM_PAGE);
    assign rom_sel = target_cycle && (page == ROM_PAGE);

    // Remember who answers, in step with the target read data.
    always_ff @(posedge hwclk)
    begin
        if (!rst_n)
        begin
            pend  <= 1'b0;
            ext_q <= 1'b0;
            ram_q <= 1'b0;
            rom_q <= 1'b0;
            mmu_q <= 1'b0;
        end
        else
        begin
            pend  <= bus.valid;
            ext_q <= ext_sel;
            ram_q <= ram_sel;
            rom_q <= rom_sel;
            mmu_q <= bus.mmu_hit;
        end
    end

    always_ff @(posedge hwclk)
    begin
        mmu_rdata_q <= bus.mmu_rdata;
        rdata       <= rdata_mux;
    end

    always_comb
    begin
        if (mmu_q)
            rdata_mux = mmu_rdata_q;
        else if (ext_q)
            rdata_mux = ext_rdata;
        else if (ram_q)
            rdata_mux = ram_rdata;
        else if (rom_q)
            rdata_mux = rom_rdata;
        else
            rdata_mux = OPEN_BUS;
    end

    always_ff @(posedge hwclk)
    begin
        if (!rst_n)
            ack <= 1'b0;
        else
            ack <= pend;
    end

    // Map regions must not overlap for any ext_addr_w the top level picks.
    a_one_target: assert property (
        @(posedge hwclk) disable iff (!rst_n) $onehot0({ext_sel, ram_sel, rom_sel}))
        else $error("more than one target selected");

endmodule
